// File: logic/lfo_params.svh
// register map is word addressed on a 3-bit bus; codes and seed are shared by RTL and testbench
`ifndef LFO_PARAMS_SVH
`define LFO_PARAMS_SVH

// wishbone word address width
`define LFO_WB_ADDR_W 3

// register map
`define LFO_ADDR_FREQ 3'd0
`define LFO_ADDR_AMD  3'd1
`define LFO_ADDR_PMD  3'd2
`define LFO_ADDR_CTRL 3'd3
`define LFO_ADDR_AM   3'd4
`define LFO_ADDR_PM   3'd5

// waveform select codes, control register bits 1:0
`define LFO_WAVE_SAW    2'd0
`define LFO_WAVE_SQUARE 2'd1
`define LFO_WAVE_TRI    2'd2
`define LFO_WAVE_NOISE  2'd3

// LFSR start value, must be nonzero
`define LFO_NOISE_SEED 8'h01

// added to the inverted rate mantissa
`define LFO_MANT_BASE 5'd16

`endif

// File: logic/lfo_pkg.sv
// shared LFO types; the rate byte is exponent in bits 7:4 and mantissa in bits 3:0
package lfo_pkg;

    // waveform or AM sample
    typedef logic [7:0] lfo_sample_t;

    // modulation depth, 0 to 127
    typedef logic [6:0] lfo_depth_t;

    // exponent in the upper nibble, mantissa in the lower
    typedef logic [7:0] lfo_rate_t;

    // waveform select code
    typedef logic [1:0] lfo_wave_t;

    // configuration held by the bus slave
    typedef struct packed {
        lfo_rate_t  rate;
        lfo_depth_t amd;
        lfo_depth_t pmd;
        lfo_wave_t  wave;
    } lfo_cfg_t;

    // generator output, valid for one cycle after a tick
    typedef struct packed {
        logic        valid;
        lfo_sample_t sample;
    } lfo_point_t;

    // classic bus handshake
    typedef enum logic {
        wb_idle,
        wb_ack
    } wb_state_e;

endpackage

// File: logic/lfo_wb_regs.sv
// wishbone classic slave, one ack per request then one idle cycle; ctrl bit 7 is not stored
`include "lfo_params.svh"

module lfo_wb_regs (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [`LFO_WB_ADDR_W-1:0] wb_adr,
    input  logic [7:0]                wb_dat_w,
    output logic [7:0]                wb_dat_r,
    output logic                      wb_ack,
    input  lfo_pkg::lfo_sample_t      am,
    input  logic [7:0]                pm,
    output lfo_pkg::lfo_cfg_t         cfg,
    output logic                      restart
);
    import lfo_pkg::*;

    wb_state_e  state;
    logic       req;
    logic [7:0] rd_mux;

    // new request only accepted from idle
    assign req = wb_cyc && wb_stb && (state == wb_idle);

    // the port wb_ack hides the enum literal, hence the scoped name
    assign wb_ack = (state == lfo_pkg::wb_ack) && wb_cyc && wb_stb;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= wb_idle;
            cfg     <= '0;
            restart <= 1'b0;
        end else begin
            restart <= 1'b0;
            if (req) begin
                state <= lfo_pkg::wb_ack;
                if (wb_we) begin
                    case (wb_adr)
                        `LFO_ADDR_FREQ: cfg.rate <= wb_dat_w;
                        `LFO_ADDR_AMD:  cfg.amd  <= wb_dat_w[6:0];
                        `LFO_ADDR_PMD:  cfg.pmd  <= wb_dat_w[6:0];
                        `LFO_ADDR_CTRL: begin
                            cfg.wave <= wb_dat_w[1:0];
                            // write-one restart, self clearing
                            restart  <= wb_dat_w[7];
                        end
                        default: ;
                    endcase
                end
            end else begin
                state <= wb_idle;
            end
        end
    end

    always_comb begin
        case (wb_adr)
            `LFO_ADDR_FREQ: rd_mux = cfg.rate;
            `LFO_ADDR_AMD:  rd_mux = {1'b0, cfg.amd};
            `LFO_ADDR_PMD:  rd_mux = {1'b0, cfg.pmd};
            `LFO_ADDR_CTRL: rd_mux = {6'd0, cfg.wave};
            `LFO_ADDR_AM:   rd_mux = am;
            `LFO_ADDR_PM:   rd_mux = pm;
            default:        rd_mux = 8'd0;
        endcase
    end

    // read data captured with the request, held through the ack cycle
    always_ff @(posedge clk) begin
        if (req) begin
            wb_dat_r <= rd_mux;
        end
    end

endmodule

// File: logic/lfo_rate_timer.sv
// tick every (16 + 15 - mantissa) << (15 - exponent) enabled cycles; a new rate waits for reload
`include "lfo_params.svh"

module lfo_rate_timer (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  logic               restart,
    input  lfo_pkg::lfo_rate_t rate,
    output logic               tick
);
    // longest interval is 31 << 15
    localparam int CNT_W = 20;

    // reset configuration is rate 0, so start a full interval of that rate
    localparam logic [CNT_W-1:0] CNT_RST = (`LFO_MANT_BASE + 20'd15) << 15;

    logic [4:0]       base;
    logic [CNT_W-1:0] reload;
    logic [CNT_W-1:0] cnt;

    // 15 - x is the bitwise inverse of a nibble
    assign base   = `LFO_MANT_BASE + {1'b0, ~rate[3:0]};
    assign reload = {{(CNT_W-5){1'b0}}, base} << ~rate[7:4];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt  <= CNT_RST;
            tick <= 1'b0;
        end else if (restart) begin
            // full interval from here, independent of cen
            cnt  <= reload;
            tick <= 1'b0;
        end else if (cen) begin
            if (cnt > 1) begin
                cnt  <= cnt - 1'b1;
                tick <= 1'b0;
            end else begin
                cnt  <= reload;
                tick <= 1'b1;
            end
        end
    end

endmodule

// File: logic/lfo_wave_gen.sv
// phase steps once per tick; the shape follows wave combinationally, noise code reads as sawtooth
`include "lfo_params.svh"

module lfo_wave_gen (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  logic                restart,
    input  logic                tick,
    input  lfo_pkg::lfo_wave_t  wave,
    output lfo_pkg::lfo_point_t point
);
    import lfo_pkg::*;

    lfo_sample_t phase;
    lfo_sample_t shaped;
    logic        valid_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase   <= '0;
            valid_q <= 1'b0;
        end else if (restart) begin
            phase   <= '0;
            valid_q <= 1'b0;
        end else if (cen) begin
            valid_q <= tick;
            if (tick) begin
                phase <= phase + 1'b1;
            end
        end
    end

    always_comb begin
        case (wave)
            `LFO_WAVE_SQUARE: shaped = phase[7] ? 8'hff : 8'h00;
            // rising half then falling half, each turning value appears twice
            `LFO_WAVE_TRI:    shaped = phase[7] ? {~phase[6:0], 1'b0} : {phase[6:0], 1'b0};
            default:          shaped = phase;
        endcase
    end

    assign point.valid  = valid_q;
    assign point.sample = shaped;

endmodule

// File: logic/lfo_noise_gen.sv
// 8-bit Fibonacci LFSR, taps 8/6/5/4, maximal length so zero is never reached
`include "lfo_params.svh"

module lfo_noise_gen (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  logic                restart,
    input  logic                tick,
    output lfo_pkg::lfo_point_t point
);
    import lfo_pkg::*;

    lfo_sample_t lfsr;
    logic        feedback;
    logic        valid_q;

    assign feedback = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr    <= `LFO_NOISE_SEED;
            valid_q <= 1'b0;
        end else if (restart) begin
            lfsr    <= `LFO_NOISE_SEED;
            valid_q <= 1'b0;
        end else if (cen) begin
            valid_q <= tick;
            if (tick) begin
                lfsr <= {lfsr[6:0], feedback};
            end
        end
    end

    assign point.valid  = valid_q;
    assign point.sample = lfsr;

endmodule

// File: logic/lfo_depth_mix.sv
// AM = s*(amd+1)>>7, PM = (s-128)*(pmd+1)>>>7; strobe is only visible in enabled cycles
`include "lfo_params.svh"

module lfo_depth_mix (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cen,
    input  lfo_pkg::lfo_wave_t   wave,
    input  lfo_pkg::lfo_depth_t  amd,
    input  lfo_pkg::lfo_depth_t  pmd,
    input  lfo_pkg::lfo_point_t  tone,
    input  lfo_pkg::lfo_point_t  noise,
    output lfo_pkg::lfo_sample_t am,
    output logic signed [7:0]    pm,
    output logic                 lfo_clk
);
    import lfo_pkg::*;

    lfo_point_t         sel;
    logic [7:0]         am_scale;
    logic [15:0]        am_prod;
    lfo_sample_t        am_next;
    logic signed [7:0]  centered;
    logic signed [8:0]  pm_scale;
    logic signed [16:0] pm_prod;
    logic signed [7:0]  pm_next;
    logic               strobe_q;

    assign sel = (wave == `LFO_WAVE_NOISE) ? noise : tone;

    // depth 127 gives unity gain
    assign am_scale = {1'b0, amd} + 8'd1;
    assign am_prod  = sel.sample * am_scale;
    assign am_next  = am_prod[14:7];

    // offset binary to two's complement
    assign centered = {~sel.sample[7], sel.sample[6:0]};
    assign pm_scale = {1'b0, {1'b0, pmd} + 8'd1};
    assign pm_prod  = centered * pm_scale;
    assign pm_next  = pm_prod[14:7];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            am       <= '0;
            pm       <= '0;
            strobe_q <= 1'b0;
        end else if (cen) begin
            strobe_q <= sel.valid;
            if (sel.valid) begin
                am <= am_next;
                pm <= pm_next;
            end
        end
    end

    // held strobe waits for the next enabled cycle
    assign lfo_clk = strobe_q & cen;

endmodule

// File: logic/lfo_top.sv
// LFO with wishbone config; everything but the bus advances on cen, AM/PM follow a tick by 2 cycles
`include "lfo_params.svh"

module lfo_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cen,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [`LFO_WB_ADDR_W-1:0] wb_adr,
    input  logic [7:0]                wb_dat_w,
    output logic [7:0]                wb_dat_r,
    output logic                      wb_ack,
    output lfo_pkg::lfo_sample_t      am,
    output logic signed [7:0]         pm,
    output logic                      lfo_clk
);
    import lfo_pkg::*;

    lfo_cfg_t   cfg;
    logic       restart;
    logic       tick;
    lfo_point_t tone;
    lfo_point_t noise;

    lfo_wb_regs i_regs (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .am       (am),
        .pm       (pm),
        .cfg      (cfg),
        .restart  (restart)
    );

    lfo_rate_timer i_timer (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .restart (restart),
        .rate    (cfg.rate),
        .tick    (tick)
    );

    lfo_wave_gen i_wave (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .restart (restart),
        .tick    (tick),
        .wave    (cfg.wave),
        .point   (tone)
    );

    lfo_noise_gen i_noise (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .restart (restart),
        .tick    (tick),
        .point   (noise)
    );

    lfo_depth_mix i_mix (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .wave    (cfg.wave),
        .amd     (cfg.amd),
        .pmd     (cfg.pmd),
        .tone    (tone),
        .noise   (noise),
        .am      (am),
        .pm      (pm),
        .lfo_clk (lfo_clk)
    );

endmodule

// File: testbench/lfo_chk.sv
// bus handshake and strobe gating checks, sampled on rising clk and idle during reset
module lfo_chk (
    input logic clk,
    input logic rst,
    input logic cen,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic lfo_clk
);
    int unsigned fails = 0;

    // ack answers a live request only
    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> (wb_cyc && wb_stb))
    else begin
        $error("wb_ack high without wb_cyc and wb_stb");
        fails++;
    end

    ack_single: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
    else begin
        $error("wb_ack high for two cycles in a row");
        fails++;
    end

    strobe_needs_cen: assert property (@(posedge clk) disable iff (rst) lfo_clk |-> cen)
    else begin
        $error("lfo_clk high while cen is low");
        fails++;
    end

    // shortest tick interval is 16 cycles
    strobe_single: assert property (@(posedge clk) disable iff (rst) lfo_clk |=> !lfo_clk)
    else begin
        $error("lfo_clk high for two cycles in a row");
        fails++;
    end

endmodule

bind lfo_top lfo_chk i_chk (
    .clk     (clk),
    .rst     (rst),
    .cen     (cen),
    .wb_cyc  (wb_cyc),
    .wb_stb  (wb_stb),
    .wb_ack  (wb_ack),
    .lfo_clk (lfo_clk)
);

// File: testbench/lfo_tb.sv
// wave tests run with amd = pmd = 127, so am follows the selected sample and pm is its offset form
`include "lfo_params.svh"

module lfo_tb;
    import lfo_pkg::*;

    logic clk, rst, cen;
    logic wb_cyc, wb_stb, wb_we, wb_ack;
    logic [`LFO_WB_ADDR_W-1:0] wb_adr;
    logic [7:0] wb_dat_w, wb_dat_r, rdata;
    lfo_sample_t am;
    logic signed [7:0] pm;
    logic lfo_clk;
    logic cen_gaps;
    logic [31:0] rng;
    int gap, errors, test_errs, tests, failed;
    int unsigned chk_base;

    lfo_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // cen is high except during the gap part of the rate test
    initial begin
        cen = 1'b0;
        forever begin
            @(posedge clk);
            #10;
            if (cen_gaps) begin
                rng = xorshift(rng);
                cen = (rng[1:0] != 2'b00);
            end else begin
                cen = 1'b1;
            end
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // shift left, new bit 0 from old bits 7, 5, 4 and 3
    function automatic lfo_sample_t lfsr_step(input lfo_sample_t v);
        return {v[6:0], v[7] ^ v[5] ^ v[4] ^ v[3]};
    endfunction

    task automatic compare_byte(input string name, input logic [7:0] expected,
                                input logic [7:0] actual);
        assert (actual === expected) else begin
            $display("** Error at %0t: %s expected 8'h%h, got 8'h%h",
                     $time, name, expected, actual);
            test_errs++;
        end
    endtask

    task automatic compare_gap(input int actual);
        assert (actual == 31) else begin
            $display("** Error at %0t: lfo_clk spacing expected 31, got %0d", $time, actual);
            test_errs++;
        end
    endtask

    task automatic end_test(input string name);
        int n;
        n = test_errs + int'(i_dut.i_chk.fails - chk_base);
        chk_base = i_dut.i_chk.fails;
        $display("test %s: %s, %0d errors", name, (n == 0) ? "ok" : "FAILED", n);
        tests++;
        errors += n;
        failed += (n != 0);
        test_errs = 0;
    endtask

    // one classic cycle, data taken while ack is high
    task automatic bus_xfer(input logic we, input logic [`LFO_WB_ADDR_W-1:0] adr,
                            input logic [7:0] dat, output logic [7:0] data);
        int n;
        @(posedge clk);
        #10;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_dat_w = dat;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!wb_ack && n < 16);
        if (!wb_ack) begin
            $display("timeout: no wb_ack for address %0d", adr);
            test_errs++;
        end
        data = wb_dat_r;
        @(posedge clk);
        #10;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    // returns at the strobe cycle with the number of enabled cycles since the last one
    task automatic wait_strobe(output int enabled);
        int n;
        enabled = 0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            enabled += cen;
        end while (!lfo_clk && n < 400);
        if (!lfo_clk) begin
            $display("timeout: no lfo_clk strobe within 400 cycles");
            test_errs++;
        end
    endtask

    // restart with a new shape and skip a strobe already in flight
    task automatic start_wave(input lfo_wave_t wave);
        bus_xfer(1'b1, `LFO_ADDR_CTRL, {1'b1, 5'd0, wave}, rdata);
        @(posedge clk);
        #10;
    endtask

    task automatic follow_wave(input lfo_wave_t wave, input int count);
        lfo_sample_t prev;
        int step, prev_step;
        prev = (wave == `LFO_WAVE_NOISE) ? `LFO_NOISE_SEED : 8'd0;
        prev_step = 0;
        repeat (count) begin
            wait_strobe(gap);
            step = int'(am) - int'(prev);
            case (wave)
                `LFO_WAVE_SAW: compare_byte("am", prev + 8'd1, am);
                `LFO_WAVE_SQUARE: begin
                    assert (am == 8'h00 || am == 8'hff) else begin
                        $display("square am is %0d at %0t, neither 0 nor 255", am, $time);
                        test_errs++;
                    end
                end
                `LFO_WAVE_TRI: begin
                    // a repeat is only allowed right after a real step
                    assert (step == 2 || step == -2 || (step == 0 && prev_step != 0)) else begin
                        $display("triangle am stepped from %0d to %0d at %0t", prev, am, $time);
                        test_errs++;
                    end
                end
                default: begin
                    compare_byte("am", lfsr_step(prev), am);
                    assert (am != 8'h00) else begin
                        $display("noise am reached zero at %0t", $time);
                        test_errs++;
                    end
                end
            endcase
            compare_byte("pm", {~am[7], am[6:0]}, pm);
            prev_step = step;
            prev = am;
        end
    endtask

    initial begin
        rst = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = 8'h00;
        cen_gaps = 1'b0;
        rng = 32'h723d_a35e;
        errors = 0;
        test_errs = 0;
        tests = 0;
        failed = 0;
        chk_base = 0;
        repeat (16) @(posedge clk);
        #10;
        rst = 1'b0;

        // depths keep 7 bits, control reads back the wave code only
        bus_xfer(1'b1, `LFO_ADDR_FREQ, 8'h5a, rdata);
        bus_xfer(1'b1, `LFO_ADDR_AMD, 8'hb3, rdata);
        bus_xfer(1'b1, `LFO_ADDR_PMD, 8'h2c, rdata);
        bus_xfer(1'b1, `LFO_ADDR_CTRL, 8'h06, rdata);
        bus_xfer(1'b0, `LFO_ADDR_FREQ, 8'h00, rdata);
        compare_byte("wb_dat_r", 8'h5a, rdata);
        bus_xfer(1'b0, `LFO_ADDR_AMD, 8'h00, rdata);
        compare_byte("wb_dat_r", 8'h33, rdata);
        bus_xfer(1'b0, `LFO_ADDR_PMD, 8'h00, rdata);
        compare_byte("wb_dat_r", 8'h2c, rdata);
        bus_xfer(1'b0, `LFO_ADDR_CTRL, 8'h00, rdata);
        compare_byte("wb_dat_r", 8'h02, rdata);
        bus_xfer(1'b0, `LFO_ADDR_AM, 8'h00, rdata);
        compare_byte("wb_dat_r", 8'h00, rdata);
        bus_xfer(1'b0, `LFO_ADDR_PM, 8'h00, rdata);
        compare_byte("wb_dat_r", 8'h00, rdata);
        // held strobe, acked every second cycle
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        repeat (6) @(posedge clk);
        #10;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        end_test("bus registers");

        bus_xfer(1'b1, `LFO_ADDR_FREQ, 8'hff, rdata);
        bus_xfer(1'b1, `LFO_ADDR_AMD, 8'h7f, rdata);
        bus_xfer(1'b1, `LFO_ADDR_PMD, 8'h7f, rdata);
        start_wave(`LFO_WAVE_SAW);
        follow_wave(`LFO_WAVE_SAW, 260);
        end_test("sawtooth");
        start_wave(`LFO_WAVE_SQUARE);
        follow_wave(`LFO_WAVE_SQUARE, 140);
        end_test("square");
        start_wave(`LFO_WAVE_TRI);
        follow_wave(`LFO_WAVE_TRI, 260);
        end_test("triangle");
        start_wave(`LFO_WAVE_NOISE);
        follow_wave(`LFO_WAVE_NOISE, 260);
        end_test("noise");

        // restart in the middle of a running sequence
        start_wave(`LFO_WAVE_SAW);
        follow_wave(`LFO_WAVE_SAW, 30);
        start_wave(`LFO_WAVE_SAW);
        follow_wave(`LFO_WAVE_SAW, 3);
        start_wave(`LFO_WAVE_NOISE);
        follow_wave(`LFO_WAVE_NOISE, 3);
        end_test("restart");

        bus_xfer(1'b1, `LFO_ADDR_FREQ, 8'hf0, rdata);
        start_wave(`LFO_WAVE_SAW);
        wait_strobe(gap);
        repeat (3) begin
            wait_strobe(gap);
            compare_gap(gap);
        end
        // cen now drops on about a quarter of the cycles
        cen_gaps = 1'b1;
        wait_strobe(gap);
        repeat (4) begin
            wait_strobe(gap);
            compare_gap(gap);
        end
        cen_gaps = 1'b0;
        end_test("rate and cen");

        $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: lfo_top.f
+incdir+logic
logic/lfo_pkg.sv
logic/lfo_wb_regs.sv
logic/lfo_rate_timer.sv
logic/lfo_wave_gen.sv
logic/lfo_noise_gen.sv
logic/lfo_depth_mix.sv
logic/lfo_top.sv
testbench/lfo_chk.sv
testbench/lfo_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module lfo_tb -f lfo_top.f -o lfo_sim || exit 1
out=$(./obj_dir/lfo_sim +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -q 'All tests passed!' && echo "simulation passed" || { echo "simulation failed"; exit 1; }
